// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := backend_tb
FILELIST := sources.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/backend_asserts.sv
`default_nettype none

module backend_asserts (
  input logic                                    clk,
  input logic                                    rst_n,
  input logic [$clog2(backend_pkg::ROB_DEPTH):0] count_i,
  input backend_pkg::rob_id_t                    head_i,
  input backend_pkg::rob_id_t                    tail_i,
  input logic                                    alloc_i,
  input logic                                    full_i,
  input logic                                    commit_valid_i
);
  int fail_count = 0;  // failed assertions so far

  count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    int'(count_i) <= backend_pkg::ROB_DEPTH)
    else begin
      $error("rob count above depth");
      fail_count++;
    end

  // pointers meeting without full means the buffer is empty
  no_commit_empty: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid_i |-> (head_i != tail_i || full_i))
    else begin
      $error("commit while rob empty");
      fail_count++;
    end

  no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(alloc_i && full_i))
    else begin
      $error("allocation while rob full");
      fail_count++;
    end

endmodule

bind reorder_buffer backend_asserts u_rob_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .count_i        (count_q),
  .head_i         (head_q),
  .tail_i         (tail_q),
  .alloc_i        (alloc_i),
  .full_i         (full_o),
  .commit_valid_i (commit_valid_o)
);

`default_nettype wire

// File: dv/backend_checker.sv
`default_nettype none

module backend_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  inst_valid_i,
  input  logic                  inst_ready_i,
  input  backend_pkg::op_e      inst_op_i,
  input  backend_pkg::arch_id_t inst_rd_i,
  input  backend_pkg::arch_id_t inst_rs1_i,
  input  backend_pkg::arch_id_t inst_rs2_i,
  input  logic                  commit_valid_i,
  input  backend_pkg::arch_id_t commit_rd_i,
  input  backend_pkg::data_t    commit_data_i,
  output int                    error_count_o,
  output int                    accept_count_o,
  output int                    commit_count_o
);
  typedef struct packed {
    backend_pkg::op_e      op;
    backend_pkg::arch_id_t rd;
    backend_pkg::arch_id_t rs1;
    backend_pkg::arch_id_t rs2;
  } inst_t;

  inst_t              pending [$];  // accepted, not yet committed
  backend_pkg::data_t model_rf [backend_pkg::NUM_ARCH_REGS];
  logic               after_reset;

  function automatic backend_pkg::data_t expected_result(
    input backend_pkg::op_e op, input backend_pkg::data_t a, input backend_pkg::data_t b);
    case (op)
      backend_pkg::OP_ADD: return a + b;
      backend_pkg::OP_SUB: return a - b;
      backend_pkg::OP_XOR: return a ^ b;
      default:             return a * b;  // low 32 bits
    endcase
  endfunction

  always @(posedge clk) begin
    inst_t              inst;
    backend_pkg::data_t exp;
    if (!rst_n) begin
      pending.delete();
      for (int r = 0; r < backend_pkg::NUM_ARCH_REGS; r++) begin
        model_rf[r] = '0;
      end
      error_count_o  = 0;
      accept_count_o = 0;
      commit_count_o = 0;
      after_reset    = 1'b1;
    end else begin
      if (after_reset && inst_ready_i !== 1'b1) begin
        $display("FAILED %0t: inst_ready low in the first cycle after reset", $time);
        error_count_o++;
      end
      after_reset = 1'b0;
      // every outstanding instruction holds one rob entry
      if (inst_ready_i && pending.size() >= backend_pkg::ROB_DEPTH) begin
        $display("FAILED %0t: inst_ready high with %0d instructions in flight",
                 $time, pending.size());
        error_count_o++;
      end
      // commit side first, a new instruction cannot retire on its accept edge
      if (commit_valid_i) begin
        commit_count_o++;
        if (accept_count_o == 0) begin
          $display("commit seen before any instruction was accepted");
          error_count_o++;
        end else if (pending.size() == 0) begin
          $display("commit seen with no instruction outstanding");
          error_count_o++;
        end else begin
          inst = pending.pop_front();
          exp  = expected_result(inst.op, model_rf[inst.rs1], model_rf[inst.rs2]);
          if (commit_rd_i !== inst.rd) begin
            $display("FAILED %0t: commit rd expected %0d got %0d", $time, inst.rd, commit_rd_i);
            error_count_o++;
          end
          if (commit_data_i !== exp) begin
            $display("FAILED %0t: commit data for r%0d expected %h got %h",
                     $time, inst.rd, exp, commit_data_i);
            error_count_o++;
          end
          if (inst.rd != '0) begin
            model_rf[inst.rd] = exp;  // r0 stays zero
          end
        end
      end
      if (inst_valid_i && inst_ready_i) begin
        pending.push_back('{inst_op_i, inst_rd_i, inst_rs1_i, inst_rs2_i});
        accept_count_o++;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/backend_tb.sv
`default_nettype none

module backend_tb;
  localparam int NUM_INSTS    = 2000;
  localparam int MAX_CYCLES   = NUM_INSTS * 10;
  localparam int RESET_CYCLES = 10;

  logic                  clk;
  logic                  rst_n;
  logic                  inst_valid;
  logic                  inst_ready;
  backend_pkg::op_e      inst_op;
  backend_pkg::arch_id_t inst_rd;
  backend_pkg::arch_id_t inst_rs1;
  backend_pkg::arch_id_t inst_rs2;
  logic                  commit_valid;
  backend_pkg::arch_id_t commit_rd;
  backend_pkg::data_t    commit_data;

  int seed;
  int cycle_count = 0;
  int sent;
  int tb_errors;
  int total_errors;
  int error_count;
  int accept_count;
  int commit_count;
  logic accepted;
  logic [31:0] coin;

  backend_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .inst_valid_i   (inst_valid),
    .inst_ready_o   (inst_ready),
    .inst_op_i      (inst_op),
    .inst_rd_i      (inst_rd),
    .inst_rs1_i     (inst_rs1),
    .inst_rs2_i     (inst_rs2),
    .commit_valid_o (commit_valid),
    .commit_rd_o    (commit_rd),
    .commit_data_o  (commit_data)
  );

  backend_checker u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .inst_valid_i   (inst_valid),
    .inst_ready_i   (inst_ready),
    .inst_op_i      (inst_op),
    .inst_rd_i      (inst_rd),
    .inst_rs1_i     (inst_rs1),
    .inst_rs2_i     (inst_rs2),
    .commit_valid_i (commit_valid),
    .commit_rd_i    (commit_rd),
    .commit_data_i  (commit_data),
    .error_count_o  (error_count),
    .accept_count_o (accept_count),
    .commit_count_o (commit_count)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run did not drain", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // middle stretch is mostly dependent multiplies to fill the rob
  task automatic drive_random_inst(input int idx);
    logic [31:0] r;
    logic        mul_phase;
    r         = $random(seed);
    mul_phase = idx >= 800 && idx < 1200;
    inst_rd   = r[2:0];
    inst_rs2  = r[5:3];
    if (mul_phase && r[9:8] != 2'b00) begin
      inst_op  = backend_pkg::OP_MUL;
      inst_rs1 = inst_rd;  // chain on the last rd
    end else begin
      inst_op  = backend_pkg::op_e'(r[7:6]);
      inst_rs1 = r[12:10];
    end
    inst_valid = 1'b1;
  endtask

  initial begin
    seed       = 32'h9d11;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst_op    = backend_pkg::OP_ADD;
    inst_rd    = '0;
    inst_rs1   = '0;
    inst_rs2   = '0;
    sent       = 0;
    tb_errors  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    while (sent < NUM_INSTS) begin
      if (!inst_valid) begin
        coin = $random(seed);
        if (coin[1:0] != 2'b00) begin
          drive_random_inst(sent);
        end
      end
      @(posedge clk);
      accepted = inst_valid && inst_ready;
      @(negedge clk);
      if (accepted) begin
        sent++;
        inst_valid = 1'b0;
      end
    end

    while (commit_count < accept_count) @(negedge clk);
    repeat (20) @(negedge clk);  // catch stray commits

    if (commit_count != accept_count) begin
      $display("commit count %0d does not match accept count %0d", commit_count, accept_count);
      tb_errors++;
    end

    total_errors = error_count + tb_errors + dut.u_rob.u_rob_asserts.fail_count;
    $display("errors %0d, accepted %0d, committed %0d", total_errors, accept_count, commit_count);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/backend_pkg.sv
verilog/issue_if.sv
verilog/rob_read_if.sv
verilog/rename_stage.sv
verilog/reorder_buffer.sv
verilog/dispatch_stage.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/backend_top.sv
dv/backend_asserts.sv
dv/backend_checker.sv
dv/backend_tb.sv

// File: verilog/alu_unit.sv
`default_nettype none

module alu_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  issue_if.sink                iss,
  input  logic                 mul_valid_i,
  input  backend_pkg::rob_id_t mul_tag_i,
  input  backend_pkg::data_t   mul_data_i,
  output logic                 alu_busy_o,
  output logic                 cdb_valid_o,
  output backend_pkg::rob_id_t cdb_tag_o,
  output backend_pkg::data_t   cdb_data_o
);
  logic                 res_vld_q;
  backend_pkg::rob_id_t res_tag_q;
  backend_pkg::data_t   res_q;
  backend_pkg::data_t   result;
  logic                 alu_issue;

  assign alu_issue = iss.valid && iss.op != backend_pkg::OP_MUL;

  always_comb begin
    case (iss.op)
      backend_pkg::OP_ADD: result = iss.a + iss.b;
      backend_pkg::OP_SUB: result = iss.a - iss.b;
      backend_pkg::OP_XOR: result = iss.a ^ iss.b;
      default:             result = '0;  // mul handled elsewhere
    endcase
  end

  // result stuck behind a multiply this cycle
  assign alu_busy_o = res_vld_q && mul_valid_i;

  assign cdb_valid_o = mul_valid_i || res_vld_q;
  assign cdb_tag_o   = mul_valid_i ? mul_tag_i : res_tag_q;
  assign cdb_data_o  = mul_valid_i ? mul_data_i : res_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_vld_q <= 1'b0;
    end else if (alu_issue) begin
      res_vld_q <= 1'b1;
    end else if (!mul_valid_i) begin
      res_vld_q <= 1'b0;  // drained onto cdb
    end
  end

  always_ff @(posedge clk) begin
    if (alu_issue) begin
      res_tag_q <= iss.rob_id;
      res_q     <= result;
    end
  end

endmodule

`default_nettype wire

// File: verilog/backend_pkg.sv
`default_nettype none

package backend_pkg;

  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] data_t;

  localparam int NUM_ARCH_REGS = 8;
  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_id_t;

  // rob index doubles as the cdb tag
  localparam int ROB_DEPTH = 8;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;

  localparam int MUL_LATENCY = 3;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_MUL = 2'd3
  } op_e;

endpackage

`default_nettype wire

// File: verilog/backend_top.sv
`default_nettype none

module backend_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  backend_pkg::op_e      inst_op_i,
  input  backend_pkg::arch_id_t inst_rd_i,
  input  backend_pkg::arch_id_t inst_rs1_i,
  input  backend_pkg::arch_id_t inst_rs2_i,
  output logic                  commit_valid_o,
  output backend_pkg::arch_id_t commit_rd_o,
  output backend_pkg::data_t    commit_data_o
);
  logic                 rob_full;
  backend_pkg::rob_id_t alloc_tag;
  logic                 slot_free;

  logic                 disp_valid;
  backend_pkg::op_e     disp_op;
  backend_pkg::rob_id_t disp_tag;
  backend_pkg::data_t   disp_a;
  backend_pkg::data_t   disp_b;
  logic                 disp_a_ready;
  logic                 disp_b_ready;
  backend_pkg::rob_id_t disp_a_tag;
  backend_pkg::rob_id_t disp_b_tag;

  backend_pkg::rob_id_t commit_tag;

  logic                 cdb_valid;
  backend_pkg::rob_id_t cdb_tag;
  backend_pkg::data_t   cdb_data;

  logic                 alu_busy;
  logic                 mul_valid;
  backend_pkg::rob_id_t mul_tag;
  backend_pkg::data_t   mul_data;

  issue_if    iss_bus ();
  rob_read_if rob_rd_bus ();

  rename_stage u_rename (
    .clk            (clk),
    .rst_n          (rst_n),
    .inst_valid_i   (inst_valid_i),
    .inst_op_i      (inst_op_i),
    .inst_rd_i      (inst_rd_i),
    .inst_rs1_i     (inst_rs1_i),
    .inst_rs2_i     (inst_rs2_i),
    .inst_ready_o   (inst_ready_o),
    .rob_full_i     (rob_full),
    .alloc_tag_i    (alloc_tag),
    .slot_free_i    (slot_free),
    .rob_rd         (rob_rd_bus.requester),
    .disp_valid_o   (disp_valid),
    .disp_op_o      (disp_op),
    .disp_tag_o     (disp_tag),
    .disp_a_o       (disp_a),
    .disp_b_o       (disp_b),
    .disp_a_ready_o (disp_a_ready),
    .disp_b_ready_o (disp_b_ready),
    .disp_a_tag_o   (disp_a_tag),
    .disp_b_tag_o   (disp_b_tag),
    .commit_valid_i (commit_valid_o),
    .commit_rd_i    (commit_rd_o),
    .commit_tag_i   (commit_tag),
    .commit_data_i  (commit_data_o)
  );

  reorder_buffer u_rob (
    .clk            (clk),
    .rst_n          (rst_n),
    .alloc_i        (disp_valid),  // every accepted instruction takes an entry
    .alloc_rd_i     (inst_rd_i),
    .alloc_tag_o    (alloc_tag),
    .full_o         (rob_full),
    .rob_rd         (rob_rd_bus.responder),
    .cdb_valid_i    (cdb_valid),
    .cdb_tag_i      (cdb_tag),
    .cdb_data_i     (cdb_data),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_tag_o   (commit_tag),
    .commit_data_o  (commit_data_o)
  );

  dispatch_stage u_dispatch (
    .clk            (clk),
    .rst_n          (rst_n),
    .disp_valid_i   (disp_valid),
    .disp_op_i      (disp_op),
    .disp_tag_i     (disp_tag),
    .disp_a_i       (disp_a),
    .disp_b_i       (disp_b),
    .disp_a_ready_i (disp_a_ready),
    .disp_b_ready_i (disp_b_ready),
    .disp_a_tag_i   (disp_a_tag),
    .disp_b_tag_i   (disp_b_tag),
    .slot_free_o    (slot_free),
    .cdb_valid_i    (cdb_valid),
    .cdb_tag_i      (cdb_tag),
    .cdb_data_i     (cdb_data),
    .alu_busy_i     (alu_busy),
    .iss            (iss_bus.source)
  );

  alu_unit u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .iss         (iss_bus.sink),
    .mul_valid_i (mul_valid),
    .mul_tag_i   (mul_tag),
    .mul_data_i  (mul_data),
    .alu_busy_o  (alu_busy),
    .cdb_valid_o (cdb_valid),
    .cdb_tag_o   (cdb_tag),
    .cdb_data_o  (cdb_data)
  );

  mul_unit u_mul (
    .clk         (clk),
    .rst_n       (rst_n),
    .iss         (iss_bus.sink),
    .mul_valid_o (mul_valid),
    .mul_tag_o   (mul_tag),
    .mul_data_o  (mul_data)
  );

endmodule

`default_nettype wire

// File: verilog/dispatch_stage.sv
`default_nettype none

module dispatch_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 disp_valid_i,
  input  backend_pkg::op_e     disp_op_i,
  input  backend_pkg::rob_id_t disp_tag_i,
  input  backend_pkg::data_t   disp_a_i,
  input  backend_pkg::data_t   disp_b_i,
  input  logic                 disp_a_ready_i,
  input  logic                 disp_b_ready_i,
  input  backend_pkg::rob_id_t disp_a_tag_i,
  input  backend_pkg::rob_id_t disp_b_tag_i,
  output logic                 slot_free_o,
  input  logic                 cdb_valid_i,
  input  backend_pkg::rob_id_t cdb_tag_i,
  input  backend_pkg::data_t   cdb_data_i,
  input  logic                 alu_busy_i,
  issue_if.source              iss
);
  logic                       slot_vld_q;
  backend_pkg::op_e           op_q;
  backend_pkg::rob_id_t       tag_q;
  backend_pkg::data_t   [1:0] opnd_q;
  logic                 [1:0] rdy_q;
  backend_pkg::rob_id_t [1:0] wait_tag_q;
  logic                       issue;

  // mul pipe never stalls
  assign issue = slot_vld_q && (&rdy_q) && (op_q == backend_pkg::OP_MUL || !alu_busy_i);
  assign slot_free_o = !slot_vld_q || issue;

  assign iss.valid  = issue;
  assign iss.op     = op_q;
  assign iss.rob_id = tag_q;
  assign iss.a      = opnd_q[0];
  assign iss.b      = opnd_q[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_vld_q <= 1'b0;
    end else if (disp_valid_i) begin
      slot_vld_q <= 1'b1;
    end else if (issue) begin
      slot_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (disp_valid_i) begin
      op_q          <= disp_op_i;
      tag_q         <= disp_tag_i;
      opnd_q[0]     <= disp_a_i;
      opnd_q[1]     <= disp_b_i;
      rdy_q         <= {disp_b_ready_i, disp_a_ready_i};
      wait_tag_q[0] <= disp_a_tag_i;
      wait_tag_q[1] <= disp_b_tag_i;
    end else begin
      for (int i = 0; i < 2; i++) begin
        // snoop cdb for pending operands
        if (!rdy_q[i] && cdb_valid_i && cdb_tag_i == wait_tag_q[i]) begin
          opnd_q[i] <= cdb_data_i;
          rdy_q[i]  <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/issue_if.sv
`default_nettype none

interface issue_if;
  logic                 valid;  // single cycle per instruction
  backend_pkg::op_e     op;
  backend_pkg::rob_id_t rob_id;
  backend_pkg::data_t   a;
  backend_pkg::data_t   b;

  modport source (output valid, op, rob_id, a, b);
  modport sink   (input  valid, op, rob_id, a, b);
endinterface

`default_nettype wire

// File: verilog/mul_unit.sv
`default_nettype none

module mul_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  issue_if.sink                iss,
  output logic                 mul_valid_o,
  output backend_pkg::rob_id_t mul_tag_o,
  output backend_pkg::data_t   mul_data_o
);
  logic [backend_pkg::MUL_LATENCY-1:0] vld_q;
  backend_pkg::rob_id_t tag_q  [backend_pkg::MUL_LATENCY];
  backend_pkg::data_t   prod_q [backend_pkg::MUL_LATENCY];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[backend_pkg::MUL_LATENCY-2:0], iss.valid && iss.op == backend_pkg::OP_MUL};
    end
  end

  always_ff @(posedge clk) begin
    tag_q[0]  <= iss.rob_id;
    prod_q[0] <= iss.a * iss.b;  // low word only
    for (int s = 1; s < backend_pkg::MUL_LATENCY; s++) begin
      tag_q[s]  <= tag_q[s-1];
      prod_q[s] <= prod_q[s-1];
    end
  end

  assign mul_valid_o = vld_q[backend_pkg::MUL_LATENCY-1];
  assign mul_tag_o   = tag_q[backend_pkg::MUL_LATENCY-1];
  assign mul_data_o  = prod_q[backend_pkg::MUL_LATENCY-1];

endmodule

`default_nettype wire

// File: verilog/rename_stage.sv
`default_nettype none

module rename_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  inst_valid_i,
  input  backend_pkg::op_e      inst_op_i,
  input  backend_pkg::arch_id_t inst_rd_i,
  input  backend_pkg::arch_id_t inst_rs1_i,
  input  backend_pkg::arch_id_t inst_rs2_i,
  output logic                  inst_ready_o,
  input  logic                  rob_full_i,
  input  backend_pkg::rob_id_t  alloc_tag_i,
  input  logic                  slot_free_i,
  rob_read_if.requester         rob_rd,
  output logic                  disp_valid_o,
  output backend_pkg::op_e      disp_op_o,
  output backend_pkg::rob_id_t  disp_tag_o,
  output backend_pkg::data_t    disp_a_o,
  output backend_pkg::data_t    disp_b_o,
  output logic                  disp_a_ready_o,
  output logic                  disp_b_ready_o,
  output backend_pkg::rob_id_t  disp_a_tag_o,
  output backend_pkg::rob_id_t  disp_b_tag_o,
  input  logic                  commit_valid_i,
  input  backend_pkg::arch_id_t commit_rd_i,
  input  backend_pkg::rob_id_t  commit_tag_i,
  input  backend_pkg::data_t    commit_data_i
);
  logic [backend_pkg::NUM_ARCH_REGS-1:0] map_vld_q;
  backend_pkg::rob_id_t map_tag_q [backend_pkg::NUM_ARCH_REGS];
  backend_pkg::data_t   rf_q      [backend_pkg::NUM_ARCH_REGS];

  backend_pkg::arch_id_t [1:0] src;
  backend_pkg::data_t    [1:0] opnd;
  logic                  [1:0] opnd_rdy;

  assign inst_ready_o = !rob_full_i && slot_free_i;
  assign disp_valid_o = inst_valid_i && inst_ready_o;
  assign disp_op_o    = inst_op_i;
  assign disp_tag_o   = alloc_tag_i;

  assign src[0] = inst_rs1_i;
  assign src[1] = inst_rs2_i;

  assign rob_rd.tag[0] = map_tag_q[inst_rs1_i];
  assign rob_rd.tag[1] = map_tag_q[inst_rs2_i];

  // operand source select, pending when the rob has no result yet
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (src[i] == '0) begin
        opnd_rdy[i] = 1'b1;
        opnd[i]     = '0;
      end else if (map_vld_q[src[i]]) begin
        opnd_rdy[i] = rob_rd.ready[i];
        opnd[i]     = rob_rd.data[i];
      end else begin
        opnd_rdy[i] = 1'b1;
        opnd[i]     = (commit_valid_i && commit_rd_i == src[i]) ? commit_data_i : rf_q[src[i]];
      end
    end
  end

  assign disp_a_o       = opnd[0];
  assign disp_b_o       = opnd[1];
  assign disp_a_ready_o = opnd_rdy[0];
  assign disp_b_ready_o = opnd_rdy[1];
  assign disp_a_tag_o   = rob_rd.tag[0];
  assign disp_b_tag_o   = rob_rd.tag[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      map_vld_q <= '0;
      for (int r = 0; r < backend_pkg::NUM_ARCH_REGS; r++) begin
        rf_q[r] <= '0;
      end
    end else begin
      if (commit_valid_i && commit_rd_i != '0) begin
        rf_q[commit_rd_i] <= commit_data_i;
        // a younger writer keeps its mapping
        if (map_tag_q[commit_rd_i] == commit_tag_i) begin
          map_vld_q[commit_rd_i] <= 1'b0;
        end
      end
      if (disp_valid_o && inst_rd_i != '0) begin
        map_vld_q[inst_rd_i] <= 1'b1;  // wins over a same-cycle clear
      end
    end
  end

  always_ff @(posedge clk) begin
    if (disp_valid_o) begin
      map_tag_q[inst_rd_i] <= alloc_tag_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
`default_nettype none

module reorder_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  alloc_i,
  input  backend_pkg::arch_id_t alloc_rd_i,
  output backend_pkg::rob_id_t  alloc_tag_o,
  output logic                  full_o,
  rob_read_if.responder         rob_rd,
  input  logic                  cdb_valid_i,
  input  backend_pkg::rob_id_t  cdb_tag_i,
  input  backend_pkg::data_t    cdb_data_i,
  output logic                  commit_valid_o,
  output backend_pkg::arch_id_t commit_rd_o,
  output backend_pkg::rob_id_t  commit_tag_o,
  output backend_pkg::data_t    commit_data_o
);
  logic [backend_pkg::ROB_DEPTH-1:0] done_q;
  backend_pkg::arch_id_t rd_q   [backend_pkg::ROB_DEPTH];
  backend_pkg::data_t    data_q [backend_pkg::ROB_DEPTH];

  backend_pkg::rob_id_t head_q;
  backend_pkg::rob_id_t tail_q;
  logic [$clog2(backend_pkg::ROB_DEPTH):0] count_q;

  assign alloc_tag_o = tail_q;
  assign full_o      = count_q == backend_pkg::ROB_DEPTH;

  // head retires once its result is in
  assign commit_valid_o = count_q != '0 && done_q[head_q];
  assign commit_rd_o    = rd_q[head_q];
  assign commit_tag_o   = head_q;
  assign commit_data_o  = data_q[head_q];

  // lookups see this cycle's broadcast too
  for (genvar i = 0; i < 2; i++) begin : g_rd_port
    logic cdb_hit;
    assign cdb_hit         = cdb_valid_i && cdb_tag_i == rob_rd.tag[i];
    assign rob_rd.ready[i] = cdb_hit || done_q[rob_rd.tag[i]];
    assign rob_rd.data[i]  = cdb_hit ? cdb_data_i : data_q[rob_rd.tag[i]];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (alloc_i) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + backend_pkg::rob_id_t'(1);
      end
      if (cdb_valid_i) begin
        done_q[cdb_tag_i] <= 1'b1;
      end
      if (commit_valid_o) begin
        head_q <= head_q + backend_pkg::rob_id_t'(1);
      end
      count_q <= count_q + alloc_i - commit_valid_o;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (cdb_valid_i) begin
      data_q[cdb_tag_i] <= cdb_data_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rob_read_if.sv
`default_nettype none

interface rob_read_if;
  // index 0 is rs1, index 1 is rs2
  backend_pkg::rob_id_t [1:0] tag;
  logic                 [1:0] ready;
  backend_pkg::data_t   [1:0] data;

  modport requester (output tag, input ready, data);
  modport responder (input tag, output ready, data);
endinterface

`default_nettype wire
